/* Makefile */
# Verilator flow for the input gate testbench

VERILATOR ?= verilator
TOP       ?= ntm_input_gate_tb
FILELIST  ?= sim.f
SEED      ?= 0
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
JOBS      ?= 4

SOURCES := $(wildcard verilog/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)

LINT_FLAGS  ?= --lint-only --timing --assert
BUILD_FLAGS ?= --binary --timing --assert -j $(JOBS)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; \
	status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed, see $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim.f */
+incdir+verif
verilog/ntm_pkg.sv
verilog/ntm_dot_product.sv
verilog/ntm_logistic_function.sv
verilog/ntm_input_gate_vector.sv
verilog/ntm_input_gate_top.sv
verif/ntm_input_gate_tb.sv

/* verif/ntm_input_gate_model.svh */
`ifndef NTM_INPUT_GATE_MODEL_SVH
`define NTM_INPUT_GATE_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Reference model of the input gate
////////////////////////////////////////////////////////////////////////////

// Sum of weight times value over one element in Q24.16
function automatic ntm_pkg::acc_t product_sum(input ntm_pkg::operand_pair_t pairs[$]);
  ntm_pkg::acc_t total;
  total = '0;
  foreach (pairs[i]) begin
    total = total + ntm_pkg::acc_t'(pairs[i].weight) * ntm_pkg::acc_t'(pairs[i].value);
  end
  return total;
endfunction

// Division rounded toward minus infinity for a positive divisor
function automatic ntm_pkg::acc_t floor_div(input ntm_pkg::acc_t num,
                                            input ntm_pkg::acc_t den);
  ntm_pkg::acc_t quot;
  quot = num / den;
  if ((num % den != 0) && (num < 0)) begin
    quot = quot - 1;
  end
  return quot;
endfunction

// Bias scaled up to Q24.16 and added before the floor back to Q8.8
function automatic ntm_pkg::acc_t join_bias(input ntm_pkg::acc_t sum,
                                            input ntm_pkg::fixed_t bias_value);
  ntm_pkg::acc_t scale;
  scale = ntm_pkg::acc_t'(2 ** ntm_pkg::FRAC_BITS);
  return floor_div(sum + ntm_pkg::acc_t'(bias_value) * scale, scale);
endfunction

// Clip to the fixed_t range
function automatic ntm_pkg::fixed_t saturate_fixed(input ntm_pkg::acc_t value);
  if (value > 40'sd32767) begin
    return 16'sh7fff;
  end
  if (value < -40'sd32768) begin
    return 16'sh8000;
  end
  return ntm_pkg::fixed_t'(value);
endfunction

// Hard sigmoid where 1.0 is 256
function automatic ntm_pkg::fixed_t hard_sigmoid(input ntm_pkg::fixed_t preact);
  int shifted;
  shifted = int'(floor_div(ntm_pkg::acc_t'(preact), 40'sd4)) + 128;
  if (shifted < 0) begin
    shifted = 0;
  end else if (shifted > 256) begin
    shifted = 256;
  end
  return ntm_pkg::fixed_t'(shifted);
endfunction

// Full gate value of one element
function automatic ntm_pkg::fixed_t expected_gate(input ntm_pkg::operand_pair_t pairs[$],
                                                  input ntm_pkg::fixed_t bias_value);
  ntm_pkg::acc_t sum;
  sum = product_sum(pairs);
  return hard_sigmoid(saturate_fixed(join_bias(sum, bias_value)));
endfunction

`endif

/* verif/ntm_input_gate_tb.sv */
`timescale 1ns/1ps

module ntm_input_gate_tb;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes, signals, scoreboard
  ////////////////////////////////////////////////////////////////////////////

  localparam int SIZE_X = 4;
  localparam int SIZE_W = 2;
  localparam int SIZE_R = 1;
  localparam int SIZE_L = 3;
  // Pairs per gate element
  localparam int TERMS = SIZE_X + SIZE_R * SIZE_W + 2 * SIZE_L;
  // Cycles allowed for any one wait
  localparam int WAIT_LIMIT = 2000;

  logic                   CLK;
  logic                   RST;
  logic                   pair_valid;
  logic                   pair_ready;
  ntm_pkg::operand_pair_t pair;
  logic                   bias_valid;
  logic                   bias_ready;
  ntm_pkg::fixed_t        bias;
  logic                   out_valid;
  logic                   out_ready;
  ntm_pkg::gate_out_t     result;

  // Expected results, oldest first
  ntm_pkg::gate_out_t     exp_q[$];
  ntm_pkg::gate_out_t     exp_head;
  int                     exp_count;
  // Operands not yet sent
  ntm_pkg::operand_pair_t pair_stream[$];
  ntm_pkg::fixed_t        bias_stream[$];

  string test_name;
  int    error_count;
  int    test_errors;
  int    tests_run;
  int    tests_bad;
  int    results_checked;
  int    elems_queued;
  int    lasts_expected;
  int    last_seen;
  logic  take_now;
  logic  saw_pair_stall;
  logic  stall_mode;
  int    stall_left;

  `include "ntm_input_gate_model.svh"

  ntm_input_gate_top #(
    .SIZE_X(SIZE_X),
    .SIZE_W(SIZE_W),
    .SIZE_R(SIZE_R),
    .SIZE_L(SIZE_L)
  ) dut (
    .CLK       (CLK),
    .RST       (RST),
    .pair_valid(pair_valid),
    .pair_ready(pair_ready),
    .pair      (pair),
    .bias_valid(bias_valid),
    .bias_ready(bias_ready),
    .bias      (bias),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .result    (result)
  );

  initial begin
    CLK = 1'b0;
    forever begin
      #10 CLK = ~CLK;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Accepted result equals the oldest expected entry
  result_check: assert property (@(posedge CLK) disable iff (RST)
      (out_valid && out_ready) |-> (result == exp_head))
    else begin
      error_count++;
      $display("FAILED %s: expected value %0d last %0b, actual value %0d last %0b",
               test_name, $sampled(exp_head.value), $sampled(exp_head.last),
               $sampled(result.value), $sampled(result.last));
    end

  // Nothing comes out beyond what was sent
  extra_check: assert property (@(posedge CLK) disable iff (RST)
      out_valid |-> (exp_count > 0))
    else begin
      error_count++;
      $display("Result offered with no element outstanding in %s", test_name);
    end

  // Stalled output keeps valid and value
  hold_check: assert property (@(posedge CLK) disable iff (RST)
      $past(out_valid && !out_ready) |-> (out_valid && result == $past(result)))
    else begin
      error_count++;
      $display("Output dropped or changed while stalled in %s", test_name);
    end

  // Idle output in reset and on the first edge after it
  reset_check: assert property (@(posedge CLK) (RST || $fell(RST)) |-> !out_valid)
    else begin
      error_count++;
      $display("out_valid high during or right after reset");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Host side processes
  ////////////////////////////////////////////////////////////////////////////

  // Back-pressure with random low stretches when enabled
  initial begin
    forever begin
      @(posedge CLK);
      #1;
      if (!stall_mode) begin
        out_ready = 1'b1;
      end else if (stall_left > 0) begin
        out_ready = 1'b0;
        stall_left--;
      end else if ($urandom_range(2) == 0) begin
        out_ready = 1'b0;
        stall_left = $urandom_range(30, 5);
      end else begin
        out_ready = 1'b1;
      end
    end
  end

  // Handshake seen mid-cycle and retired just after the edge
  initial begin
    forever begin
      @(negedge CLK);
      take_now = out_valid && out_ready && !RST;
      if (pair_valid && !pair_ready) begin
        saw_pair_stall = 1'b1;
      end
      if (take_now && result.last) begin
        last_seen++;
      end
      @(posedge CLK);
      #1;
      if (take_now) begin
        if (exp_q.size() > 0) begin
          void'(exp_q.pop_front());
        end
        refresh_head();
        results_checked++;
      end
    end
  end

  function automatic void refresh_head();
    exp_head  = (exp_q.size() > 0) ? exp_q[0] : '0;
    exp_count = exp_q.size();
  endfunction

  function automatic ntm_pkg::fixed_t random_fixed(input int mag);
    return ntm_pkg::fixed_t'(int'($urandom_range(2 * mag)) - mag);
  endfunction

  // One element onto the streams with its expected result
  function automatic void queue_element(input ntm_pkg::operand_pair_t pairs[$],
                                        input ntm_pkg::fixed_t bias_value,
                                        input ntm_pkg::fixed_t value);
    ntm_pkg::gate_out_t entry;
    entry.value = value;
    // Framing follows the element count since reset
    entry.last  = (elems_queued % SIZE_L) == (SIZE_L - 1);
    foreach (pairs[i]) begin
      pair_stream.push_back(pairs[i]);
    end
    bias_stream.push_back(bias_value);
    exp_q.push_back(entry);
    refresh_head();
    elems_queued++;
    if (entry.last) begin
      lasts_expected++;
    end
  endfunction

  task automatic add_small_elements(input int n, input int mag);
    ntm_pkg::operand_pair_t pairs[$];
    ntm_pkg::operand_pair_t p;
    ntm_pkg::fixed_t        bias_value;
    for (int e = 0; e < n; e++) begin
      pairs.delete();
      for (int t = 0; t < TERMS; t++) begin
        p.weight = random_fixed(mag);
        p.value  = random_fixed(mag);
        pairs.push_back(p);
      end
      bias_value = random_fixed(2 * mag);
      queue_element(pairs, bias_value, expected_gate(pairs, bias_value));
    end
  endtask

  // All pairs equal so the clamp rule fixes the result
  task automatic add_const_element(input ntm_pkg::fixed_t w, input ntm_pkg::fixed_t v,
                                   input ntm_pkg::fixed_t bias_value,
                                   input ntm_pkg::fixed_t expected);
    ntm_pkg::operand_pair_t pairs[$];
    ntm_pkg::operand_pair_t p;
    p.weight = w;
    p.value  = v;
    repeat (TERMS) begin
      pairs.push_back(p);
    end
    queue_element(pairs, bias_value, expected);
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout in %s while waiting for %s", test_name, what);
    $display("Test failed");
    $finish;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge CLK);
      #1;
    end
  endtask

  // Entered and left just after a rising edge
  task automatic send_pair(input ntm_pkg::operand_pair_t p);
    int waited;
    waited = 0;
    pair_valid = 1'b1;
    pair = p;
    @(negedge CLK);
    while (!pair_ready) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_on_timeout("pair_ready");
      end
      @(negedge CLK);
    end
    @(posedge CLK);
    #1;
    pair_valid = 1'b0;
  endtask

  task automatic send_bias(input ntm_pkg::fixed_t bias_value);
    int waited;
    waited = 0;
    bias_valid = 1'b1;
    bias = bias_value;
    @(negedge CLK);
    while (!bias_ready) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_on_timeout("bias_ready");
      end
      @(negedge CLK);
    end
    @(posedge CLK);
    #1;
    bias_valid = 1'b0;
  endtask

  // Pair and bias streams run apart with random gaps on each
  task automatic run_streams(input int pair_gap, input int bias_delay);
    fork
      begin
        while (pair_stream.size() > 0) begin
          idle($urandom_range(pair_gap));
          send_pair(pair_stream.pop_front());
        end
      end
      begin
        while (bias_stream.size() > 0) begin
          idle($urandom_range(bias_delay));
          send_bias(bias_stream.pop_front());
        end
      end
    join
  endtask

  task automatic set_stall(input logic enable, input int first_stretch);
    @(negedge CLK);
    stall_mode = enable;
    stall_left = first_stretch;
    @(posedge CLK);
    #1;
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = error_count;
    tests_run++;
  endtask

  // Drain all outstanding results, then report the test
  task automatic finish_test();
    int waited;
    waited = 0;
    @(negedge CLK);
    while (exp_count > 0) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_on_timeout("results");
      end
      @(negedge CLK);
    end
    frame_check: assert (last_seen == lasts_expected) else begin
      error_count++;
      $display("Framing wrong in %s, %0d last flags seen where %0d were due",
               test_name, last_seen, lasts_expected);
    end
    $display("test %-16s done, %0d errors", test_name, error_count - test_errors);
    if (error_count != test_errors) begin
      tests_bad++;
    end
    @(posedge CLK);
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    RST = 1'b1;
    pair_valid = 1'b0;
    pair = '0;
    bias_valid = 1'b0;
    bias = '0;
    out_ready = 1'b0;
    stall_mode = 1'b0;
    stall_left = 0;
    take_now = 1'b0;
    saw_pair_stall = 1'b0;
    error_count = 0;
    tests_run = 0;
    tests_bad = 0;
    results_checked = 0;
    elems_queued = 0;
    lasts_expected = 0;
    last_seen = 0;
    refresh_head();
    void'($urandom(32'h151f));
    repeat (4) @(posedge CLK);
    #1;
    RST = 1'b0;

    // First vector straight out of reset
    start_test("reset_state");
    add_small_elements(SIZE_L, 128);
    run_streams(0, 0);
    finish_test();

    start_test("basic_gate");
    add_small_elements(6, 128);
    run_streams(3, 3);
    finish_test();

    // Preactivation at both limits, then exactly zero
    start_test("saturation");
    add_const_element(16'sh7fff, 16'sh7fff, 16'sh7fff, 16'sd256);
    add_const_element(16'sh8000, 16'sh7fff, 16'sh8000, 16'sd0);
    add_const_element(16'sh0000, 16'sh0000, 16'sh0000, 16'sd128);
    run_streams(1, 1);
    finish_test();

    start_test("vector_framing");
    add_small_elements(3 * SIZE_L, 64);
    run_streams(0, 0);
    finish_test();

    // Long first stall fills all three stages
    start_test("backpressure");
    saw_pair_stall = 1'b0;
    set_stall(1'b1, 40);
    add_small_elements(12, 128);
    run_streams(0, 0);
    stall_check: assert (saw_pair_stall) else begin
      error_count++;
      $display("pair_ready never dropped with the output stalled in %s", test_name);
    end
    finish_test();
    set_stall(1'b0, 0);

    start_test("bias_late");
    add_small_elements(6, 128);
    run_streams(0, 25);
    finish_test();

    start_test("bias_early");
    add_small_elements(6, 128);
    run_streams(6, 0);
    finish_test();

    $display("Summary: %0d tests, %0d with errors, %0d results checked, %0d errors",
             tests_run, tests_bad, results_checked, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verilog/ntm_dot_product.sv */
`timescale 1ns/1ps

// Streaming multiply-accumulate over TERMS operand pairs
module ntm_dot_product #(
  parameter int TERMS = 12
) (
  input  logic                   CLK,
  input  logic                   RST,

  // Operand pair stream
  input  logic                   pair_valid,
  output logic                   pair_ready,
  input  ntm_pkg::operand_pair_t pair,

  // Finished sum held until taken
  output logic                   sum_valid,
  input  logic                   sum_ready,
  output ntm_pkg::acc_t          sum
);

  // Wide enough for TERMS == 1 as well
  localparam int CNT_W = $clog2(TERMS + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  logic [CNT_W-1:0]                            term_cnt;
  ntm_pkg::acc_t                               acc;
  ntm_pkg::acc_t                               acc_base;
  logic signed [2*$bits(ntm_pkg::fixed_t)-1:0] product;
  logic                                        pair_fire;
  logic                                        sum_fire;
  logic                                        last_term;

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////////////////////

  assign sum_fire  = sum_valid && sum_ready;
  // Input stalls only while a finished sum waits
  assign pair_ready = !sum_valid || sum_ready;
  assign pair_fire  = pair_valid && pair_ready;
  assign last_term  = (term_cnt == CNT_W'(TERMS - 1));

  // Q16.16 product of one pair
  assign product = pair.weight * pair.value;

  // Taking the sum restarts from zero in the same cycle
  assign acc_base = sum_fire ? '0 : acc;

  assign sum = acc;

  ////////////////////////////////////////////////////////////////////////////
  // Accumulator and term counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      term_cnt  <= '0;
      acc       <= '0;
      sum_valid <= 1'b0;
    end else begin
      // Add in the accepting cycle
      if (pair_fire) begin
        acc <= acc_base + ntm_pkg::acc_t'(product);
      end else if (sum_fire) begin
        acc <= '0;
      end

      // Pair count within the element
      if (pair_fire) begin
        term_cnt <= last_term ? '0 : term_cnt + 1'b1;
      end

      // Sum complete on the last pair
      if (pair_fire && last_term) begin
        sum_valid <= 1'b1;
      end else if (sum_fire) begin
        sum_valid <= 1'b0;
      end
    end
  end

endmodule

/* verilog/ntm_input_gate_top.sv */
`timescale 1ns/1ps

// Input gate subsystem with its sizes fixed
module ntm_input_gate_top #(
  // Controller input width
  parameter int SIZE_X = 4,
  // Word width of one memory row
  parameter int SIZE_W = 2,
  // Read heads
  parameter int SIZE_R = 1,
  // Gate vector length
  parameter int SIZE_L = 3
) (
  input  logic                   CLK,
  input  logic                   RST,

  // Operand pairs from the host
  input  logic                   pair_valid,
  output logic                   pair_ready,
  input  ntm_pkg::operand_pair_t pair,

  // Bias from the host
  input  logic                   bias_valid,
  output logic                   bias_ready,
  input  ntm_pkg::fixed_t        bias,

  // Gate values to the host
  output logic                   out_valid,
  input  logic                   out_ready,
  output ntm_pkg::gate_out_t     result
);

  ntm_input_gate_vector #(
    .SIZE_X(SIZE_X),
    .SIZE_W(SIZE_W),
    .SIZE_R(SIZE_R),
    .SIZE_L(SIZE_L)
  ) input_gate (
    .CLK       (CLK),
    .RST       (RST),
    .pair_valid(pair_valid),
    .pair_ready(pair_ready),
    .pair      (pair),
    .bias_valid(bias_valid),
    .bias_ready(bias_ready),
    .bias      (bias),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .result    (result)
  );

endmodule

/* verilog/ntm_input_gate_vector.sv */
`timescale 1ns/1ps

// Input gate i(l) = sigmoid(W*x + K*r + U*h(t-1) + U*h(l-1) + b)
// Pairs stream through one accumulator, bias joins after it
module ntm_input_gate_vector #(
  parameter int SIZE_X = 4,
  parameter int SIZE_W = 2,
  parameter int SIZE_R = 1,
  parameter int SIZE_L = 3
) (
  input  logic                   CLK,
  input  logic                   RST,

  // Operand pairs, all terms of one element in order
  input  logic                   pair_valid,
  output logic                   pair_ready,
  input  ntm_pkg::operand_pair_t pair,

  // One bias per element
  input  logic                   bias_valid,
  output logic                   bias_ready,
  input  ntm_pkg::fixed_t        bias,

  // Gate values with vector framing
  output logic                   out_valid,
  input  logic                   out_ready,
  output ntm_pkg::gate_out_t     result
);

  ////////////////////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////////////////////

  // W*x, then K*r over all read heads, then both U*h terms
  localparam int TERMS = SIZE_X + SIZE_R * SIZE_W + 2 * SIZE_L;

  localparam int ELEM_W = (SIZE_L > 1) ? $clog2(SIZE_L) : 1;

  // fixed_t limits in accumulator width
  localparam ntm_pkg::acc_t SAT_MAX = 40'sd32767;
  localparam ntm_pkg::acc_t SAT_MIN = -40'sd32768;

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  // Accumulator side
  logic               sum_valid;
  logic               sum_ready;
  ntm_pkg::acc_t      sum;

  // Bias join
  logic               join_open;
  logic               join_fire;
  ntm_pkg::acc_t      joined;
  ntm_pkg::acc_t      rescaled;
  ntm_pkg::fixed_t    preact_next;

  // Preactivation register
  logic               act_valid;
  logic               act_ready;
  ntm_pkg::fixed_t    preact;

  // Output side
  ntm_pkg::fixed_t    gate_value;
  logic [ELEM_W-1:0]  elem_cnt;
  logic               elem_last;

  ////////////////////////////////////////////////////////////////////////////
  // Dot product
  ////////////////////////////////////////////////////////////////////////////

  ntm_dot_product #(
    .TERMS(TERMS)
  ) dot_product (
    .CLK       (CLK),
    .RST       (RST),
    .pair_valid(pair_valid),
    .pair_ready(pair_ready),
    .pair      (pair),
    .sum_valid (sum_valid),
    .sum_ready (sum_ready),
    .sum       (sum)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Bias join and rescale
  ////////////////////////////////////////////////////////////////////////////

  // Preactivation register free or emptying
  assign join_open = !act_valid || act_ready;

  // Sum and bias leave together
  assign sum_ready  = bias_valid && join_open;
  assign bias_ready = sum_valid && join_open;
  assign join_fire  = sum_valid && bias_valid && join_open;

  // Bias lifted to Q24.16 before the add
  assign joined   = sum + (ntm_pkg::acc_t'(bias) <<< ntm_pkg::FRAC_BITS);
  // Floor back to Q8.8
  assign rescaled = joined >>> ntm_pkg::FRAC_BITS;

  always_comb begin
    if (rescaled > SAT_MAX) begin
      preact_next = ntm_pkg::fixed_t'(SAT_MAX);
    end else if (rescaled < SAT_MIN) begin
      preact_next = ntm_pkg::fixed_t'(SAT_MIN);
    end else begin
      preact_next = ntm_pkg::fixed_t'(rescaled);
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      act_valid <= 1'b0;
    end else if (join_fire) begin
      act_valid <= 1'b1;
    end else if (act_ready) begin
      act_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (join_fire) begin
      preact <= preact_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Logistic and framing
  ////////////////////////////////////////////////////////////////////////////

  ntm_logistic_function logistic (
    .CLK      (CLK),
    .RST      (RST),
    .act_valid(act_valid),
    .act_ready(act_ready),
    .preact   (preact),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .act      (gate_value)
  );

  // Index of the element now at the output
  assign elem_last = (elem_cnt == ELEM_W'(SIZE_L - 1));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      elem_cnt <= '0;
    end else if (out_valid && out_ready) begin
      elem_cnt <= elem_last ? '0 : elem_cnt + 1'b1;
    end
  end

  assign result = '{value: gate_value, last: elem_last};

endmodule

/* verilog/ntm_logistic_function.sv */
`timescale 1ns/1ps

// One-deep registered hard sigmoid clamp(0.5 + x/4, 0, 1)
module ntm_logistic_function (
  input  logic            CLK,
  input  logic            RST,

  // Preactivation in
  input  logic            act_valid,
  output logic            act_ready,
  input  ntm_pkg::fixed_t preact,

  // Gate value out
  output logic            out_valid,
  input  logic            out_ready,
  output ntm_pkg::fixed_t act
);

  // 0.5 and 1.0 in Q8.8
  localparam logic signed [16:0] HALF = 17'sd128;
  localparam logic signed [16:0] ONE  = 17'sd256;

  ntm_pkg::fixed_t    quarter;
  logic signed [16:0] shifted;
  ntm_pkg::fixed_t    clamped;

  // Floor divide by four
  assign quarter = preact >>> 2;
  // Extra bit keeps the offset sum from wrapping
  assign shifted = quarter + HALF;

  always_comb begin
    if (shifted < 0) begin
      clamped = '0;
    end else if (shifted > ONE) begin
      clamped = ntm_pkg::fixed_t'(ONE);
    end else begin
      clamped = ntm_pkg::fixed_t'(shifted);
    end
  end

  // Free when empty or emptying
  assign act_ready = !out_valid || out_ready;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
    end else if (act_valid && act_ready) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Output payload
  always_ff @(posedge CLK) begin
    if (act_valid && act_ready) begin
      act <= clamped;
    end
  end

endmodule

/* verilog/ntm_pkg.sv */
// Shared fixed-point types for the input gate datapath
package ntm_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Fixed-point format
  ////////////////////////////////////////////////////////////////////////////

  // Fraction bits of one Q8.8 value
  parameter int FRAC_BITS = 8;

  // One Q8.8 signed value
  // Weights, vector elements, bias and gate output
  typedef logic signed [15:0] fixed_t;

  // Q24.16 accumulator for sums of Q8.8 products
  // Spare high bits absorb a full element without overflow
  typedef logic signed [39:0] acc_t;

  ////////////////////////////////////////////////////////////////////////////
  // Stream payloads
  ////////////////////////////////////////////////////////////////////////////

  // One multiply operand pair from the host
  typedef struct packed {
    // Matrix coefficient (W, K or U)
    fixed_t weight;
    // Vector element (x, r or h)
    fixed_t value;
  } operand_pair_t;

  // One gate element back to the host
  typedef struct packed {
    // Hard-sigmoid result where 1.0 is 256
    fixed_t value;
    // High on element SIZE_L-1 of a vector
    logic   last;
  } gate_out_t;

endpackage
